// ==== include/dl_defs.svh ====
// Constants for the download stream block.
// Include wherever a FIFO depth, a loader file index, the default palette
// or one of the known colour bootrom checksums is needed.

`ifndef DL_DEFS_SVH
`define DL_DEFS_SVH

// Record FIFO entries, also the credit count after reset (power of two)
`define DL_FIFO_DEPTH 4

// Loader file indices
`define DL_FT_PALETTE  8'd3
`define DL_FT_CGB_BOOT 8'd4
`define DL_FT_DMG_BOOT 8'd5
`define DL_FT_CHEAT    8'hFF

// Four 24-bit colours in the upper 96 bits
`define DL_PALETTE_RESET 128'h828214517356305A5F1A3B4900000000

// Byte sums of the known colour bootroms
`define DL_CGB_MISTER_SUM   18'h2CE10
`define DL_CGB_ORIGINAL_SUM 18'h2F3EA

`endif

// ==== design/dl_pkg.sv ====
// Types shared by the download stream modules and the testbench checker.
// Import by wildcard inside a module body; use scoped names in port lists.

package dl_pkg;

	// Kinds of record passed from the classifier to the sink
	typedef enum logic [2:0] {
		kind_palette   = 3'd0,
		kind_cheat     = 3'd1,
		kind_cgb_start = 3'd2,
		kind_cgb_word  = 3'd3,
		kind_dmg_start = 3'd4
	} dl_kind_t;

	// One 16-bit loader word
	typedef logic [15:0] dl_word_t;

	// Low address bits, selects a cheat field
	typedef logic [3:0] dl_field_t;

	// Colour bootrom byte sum
	typedef logic [17:0] dl_sum_t;

	// Cheat code as seen by the core:
	// bit 128 load strobe, 127:96 flags, 95:64 address,
	// 63:32 compare, 31:0 replace
	typedef logic [128:0] dl_code_t;

	// Four packed palette colours
	typedef logic [127:0] dl_palette_t;

endpackage

// ==== design/dl_classify.sv ====
// Front end of the download stream.
// Accepts loader words, turns them into records for the FIFO and keeps one
// credit per free FIFO entry. Raises ioctl_wait when the credits run out or
// a bootrom start record still has to be sent.

`timescale 1ns/10ps
`include "dl_defs.svh"

module dl_classify (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  dl_pkg::dl_field_t ioctl_addr,
	input  dl_pkg::dl_word_t  ioctl_dout,
	input  logic              credit_return,
	output logic              ioctl_wait,
	output logic              rec_push,
	output dl_pkg::dl_kind_t  rec_kind,
	output dl_pkg::dl_field_t rec_field,
	output dl_pkg::dl_word_t  rec_data
);
	import dl_pkg::*;

	localparam int cnt_w = $clog2(`DL_FIFO_DEPTH + 1);

	logic             pal_dl, cheat_dl, cgb_dl, dmg_dl;
	logic [1:0]       boot_dl_r;
	logic             cgb_start_seen, dmg_start_seen, start_seen, start_now;
	logic             pending, pending_next;
	dl_kind_t         pend_kind, start_kind, word_kind;
	logic             word_acc, have_credit;
	logic             push_start, push_held, push_word, push_any, hold_word;
	logic             held, held_next;
	dl_kind_t         held_kind;
	dl_field_t        held_field;
	dl_word_t         held_data;
	logic [cnt_w-1:0] credits, credits_next;

	////////////////////////////////////////////////////////////////////////////
	// Index decode and start detection

	assign pal_dl   = ioctl_download && (ioctl_index == `DL_FT_PALETTE);
	assign cheat_dl = ioctl_download && (ioctl_index == `DL_FT_CHEAT);
	assign cgb_dl   = ioctl_download && (ioctl_index == `DL_FT_CGB_BOOT);
	assign dmg_dl   = ioctl_download && (ioctl_index == `DL_FT_DMG_BOOT);

	assign cgb_start_seen = cgb_dl & ~boot_dl_r[0];
	assign dmg_start_seen = dmg_dl & ~boot_dl_r[1];
	assign start_seen     = cgb_start_seen | dmg_start_seen;
	assign start_now      = pending | start_seen;
	assign start_kind     = pending ? pend_kind :
	                        (cgb_start_seen ? kind_cgb_start : kind_dmg_start);

	// Mono bootrom words carry nothing for the sink, only their start does
	assign word_acc  = ioctl_download & ioctl_wr & ~ioctl_wait &
	                   (pal_dl | cheat_dl | cgb_dl);
	assign word_kind = pal_dl ? kind_palette : (cheat_dl ? kind_cheat : kind_cgb_word);

	////////////////////////////////////////////////////////////////////////////
	// Push selection, start record first

	assign have_credit = (credits != '0);
	assign push_start  = start_now & have_credit;
	assign push_held   = ~start_now & held & have_credit;
	assign push_word   = ~start_now & ~held & word_acc & have_credit;
	assign push_any    = push_start | push_held | push_word;

	// A word arriving with a start record waits one slot
	assign hold_word    = word_acc & ~push_word;
	assign held_next    = hold_word | (held & ~push_held);
	assign pending_next = start_now & ~push_start;
	assign credits_next = credits - cnt_w'(push_any) + cnt_w'(credit_return);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_dl_r  <= '0;
			pending    <= 1'b0;
			held       <= 1'b0;
			credits    <= cnt_w'(`DL_FIFO_DEPTH);
			ioctl_wait <= 1'b0;
			rec_push   <= 1'b0;
		end else begin
			boot_dl_r  <= {dmg_dl, cgb_dl};
			pending    <= pending_next;
			held       <= held_next;
			credits    <= credits_next;
			ioctl_wait <= (credits_next == '0) | pending_next | held_next;
			rec_push   <= push_any;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_seen && !pending)
			pend_kind <= start_kind;
		if (hold_word) begin
			held_kind  <= word_kind;
			held_field <= ioctl_addr;
			held_data  <= ioctl_dout;
		end
		if (push_start) begin
			rec_kind  <= start_kind;
			rec_field <= '0;
			rec_data  <= '0;
		end else if (push_held) begin
			rec_kind  <= held_kind;
			rec_field <= held_field;
			rec_data  <= held_data;
		end else begin
			rec_kind  <= word_kind;
			rec_field <= ioctl_addr;
			rec_data  <= ioctl_dout;
		end
	end

	// Returned credits must never outnumber the FIFO entries
	a_credit_max: assert property (@(posedge clk_sys) disable iff (reset)
		credits <= cnt_w'(`DL_FIFO_DEPTH))
		else $error("credit count above FIFO depth");

endmodule

// ==== design/dl_credit_fifo.sv ====
// Record FIFO between the classifier and the sink.
// Writes on rec_push, presents the oldest record at the head and hands one
// credit back to the classifier for every record the sink pops.

`timescale 1ns/10ps
`include "dl_defs.svh"

module dl_credit_fifo (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              rec_push,
	input  dl_pkg::dl_kind_t  rec_kind,
	input  dl_pkg::dl_field_t rec_field,
	input  dl_pkg::dl_word_t  rec_data,
	input  logic              rec_pop,
	output logic              rec_avail,
	output dl_pkg::dl_kind_t  head_kind,
	output dl_pkg::dl_field_t head_field,
	output dl_pkg::dl_word_t  head_data,
	output logic              credit_return
);
	import dl_pkg::*;

	localparam int ptr_w = $clog2(`DL_FIFO_DEPTH);

	dl_kind_t   kind_mem  [`DL_FIFO_DEPTH];
	dl_field_t  field_mem [`DL_FIFO_DEPTH];
	dl_word_t   data_mem  [`DL_FIFO_DEPTH];
	// Extra top bit tells full from empty
	logic [ptr_w:0] wr_ptr, rd_ptr;
	logic           full;

	assign rec_avail = (wr_ptr != rd_ptr);
	assign full      = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
	                   (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

	// Head is read straight from the store
	assign head_kind  = kind_mem[rd_ptr[ptr_w-1:0]];
	assign head_field = field_mem[rd_ptr[ptr_w-1:0]];
	assign head_data  = data_mem[rd_ptr[ptr_w-1:0]];

	always_ff @(posedge clk_sys) begin
		if (rec_push) begin
			kind_mem[wr_ptr[ptr_w-1:0]]  <= rec_kind;
			field_mem[wr_ptr[ptr_w-1:0]] <= rec_field;
			data_mem[wr_ptr[ptr_w-1:0]]  <= rec_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			credit_return <= 1'b0;
		end else begin
			if (rec_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (rec_pop)
				rd_ptr <= rd_ptr + 1'b1;
			credit_return <= rec_pop;
		end
	end

	// The credit count upstream keeps these from ever firing
	a_no_push_full: assert property (@(posedge clk_sys) disable iff (reset)
		rec_push |-> !full)
		else $error("record pushed into a full FIFO");

	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (reset)
		rec_pop |-> rec_avail)
		else $error("record popped from an empty FIFO");

endmodule

// ==== design/dl_sink.sv ====
// Back end of the download stream.
// Applies records from the FIFO head: shifts the colour palette, assembles
// cheat codes, sums the colour bootrom bytes and keeps the custom bootrom
// flags. The checksum adder takes one byte per cycle, so a colour bootrom
// word stays at the head for two cycles.

`timescale 1ns/10ps
`include "dl_defs.svh"

module dl_sink (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                is_gbc,
	input  logic                rec_avail,
	input  dl_pkg::dl_kind_t    head_kind,
	input  dl_pkg::dl_field_t   head_field,
	input  dl_pkg::dl_word_t    head_data,
	output logic                rec_pop,
	output dl_pkg::dl_palette_t palette,
	output dl_pkg::dl_code_t    gg_code,
	output logic                gg_code_valid,
	output dl_pkg::dl_sum_t     checksum,
	output logic                using_real_cgb_boot,
	output logic                boot_gba_available,
	output logic                fastboot_available
);
	import dl_pkg::*;

	logic         byte_phase;
	logic         cgb_high;
	logic         custom_cgb, custom_dmg;
	logic [127:0] code_q;
	logic         sum_mister;

	// High byte of a colour bootrom word goes in first, the pop waits a cycle
	assign cgb_high = rec_avail && (head_kind == kind_cgb_word) && !byte_phase;
	assign rec_pop  = rec_avail && ((head_kind != kind_cgb_word) || byte_phase);

	////////////////////////////////////////////////////////////////////////////
	// Palette and checksum, control state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette       <= `DL_PALETTE_RESET;
			checksum      <= '0;
			custom_cgb    <= 1'b0;
			custom_dmg    <= 1'b0;
			byte_phase    <= 1'b0;
			gg_code_valid <= 1'b0;
		end else begin
			gg_code_valid <= 1'b0;
			if (cgb_high) begin
				checksum   <= checksum + dl_sum_t'(head_data[15:8]);
				byte_phase <= 1'b1;
			end
			if (rec_pop) begin
				case (head_kind)
					kind_palette:
						palette <= {palette[111:0], head_data[7:0], head_data[15:8]};
					kind_cheat:
						gg_code_valid <= (head_field == 4'd14);
					kind_cgb_start: begin
						checksum   <= '0;
						custom_cgb <= 1'b1;
					end
					kind_dmg_start:
						custom_dmg <= 1'b1;
					kind_cgb_word: begin
						checksum   <= checksum + dl_sum_t'(head_data[7:0]);
						byte_phase <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Cheat code fields, big endian words from the loader

	always_ff @(posedge clk_sys) begin
		if (rec_pop && head_kind == kind_cheat) begin
			case (head_field)
				4'd0:  code_q[111:96]  <= head_data;
				4'd2:  code_q[127:112] <= head_data;
				4'd4:  code_q[79:64]   <= head_data;
				4'd6:  code_q[95:80]   <= head_data;
				4'd8:  code_q[47:32]   <= head_data;
				4'd10: code_q[63:48]   <= head_data;
				4'd12: code_q[15:0]    <= head_data;
				4'd14: code_q[31:16]   <= head_data;
				default: ;
			endcase
		end
	end

	// Top bit is the load strobe for the core
	assign gg_code = {gg_code_valid, code_q};

	////////////////////////////////////////////////////////////////////////////
	// Bootrom features

	assign sum_mister          = (checksum == `DL_CGB_MISTER_SUM);
	assign using_real_cgb_boot = (checksum == `DL_CGB_ORIGINAL_SUM);
	assign boot_gba_available  = !custom_cgb || using_real_cgb_boot || sum_mister;
	// Only MiSTer built bootroms know the fast boot path
	assign fastboot_available  = !((is_gbc && custom_cgb && !sum_mister) ||
	                               (!is_gbc && custom_dmg));

	// The low byte still needs the same colour bootrom word at the head
	a_phase_head: assert property (@(posedge clk_sys) disable iff (reset)
		byte_phase |-> rec_avail && (head_kind == kind_cgb_word))
		else $error("byte phase set without a colour bootrom word at the head");

endmodule

// ==== design/dl_top.sv ====
// Download stream top level.
// Loader words enter the classifier, pass through the credit FIFO and are
// applied by the sink, which drives the palette, cheat and bootrom outputs.

`timescale 1ns/10ps

module dl_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                is_gbc,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  dl_pkg::dl_field_t   ioctl_addr,
	input  dl_pkg::dl_word_t    ioctl_dout,
	output logic                ioctl_wait,
	output dl_pkg::dl_palette_t palette,
	output dl_pkg::dl_code_t    gg_code,
	output logic                gg_code_valid,
	output dl_pkg::dl_sum_t     checksum,
	output logic                using_real_cgb_boot,
	output logic                boot_gba_available,
	output logic                fastboot_available
);
	import dl_pkg::*;

	// Producer to FIFO
	logic      rec_push, credit_return;
	dl_kind_t  rec_kind;
	dl_field_t rec_field;
	dl_word_t  rec_data;

	// FIFO to sink
	logic      rec_avail, rec_pop;
	dl_kind_t  head_kind;
	dl_field_t head_field;
	dl_word_t  head_data;

	dl_classify u_classify (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.credit_return  (credit_return),
		.ioctl_wait     (ioctl_wait),
		.rec_push       (rec_push),
		.rec_kind       (rec_kind),
		.rec_field      (rec_field),
		.rec_data       (rec_data)
	);

	dl_credit_fifo u_fifo (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rec_push      (rec_push),
		.rec_kind      (rec_kind),
		.rec_field     (rec_field),
		.rec_data      (rec_data),
		.rec_pop       (rec_pop),
		.rec_avail     (rec_avail),
		.head_kind     (head_kind),
		.head_field    (head_field),
		.head_data     (head_data),
		.credit_return (credit_return)
	);

	dl_sink u_sink (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.is_gbc              (is_gbc),
		.rec_avail           (rec_avail),
		.head_kind           (head_kind),
		.head_field          (head_field),
		.head_data           (head_data),
		.rec_pop             (rec_pop),
		.palette             (palette),
		.gg_code             (gg_code),
		.gg_code_valid       (gg_code_valid),
		.checksum            (checksum),
		.using_real_cgb_boot (using_real_cgb_boot),
		.boot_gba_available  (boot_gba_available),
		.fastboot_available  (fastboot_available)
	);

endmodule

// ==== test/dl_checker.sv ====
// Scoreboard for the download stream testbench.
// Watches the DUT ports and rebuilds the expected palette, cheat codes,
// checksum and bootrom flags from every accepted loader word.
// The testbench calls compare_all after each download and reads the counts.

`timescale 1ns/10ps
`include "dl_defs.svh"

module dl_checker (
	input logic                clk_sys,
	input logic                reset,
	input logic                is_gbc,
	input logic                ioctl_download,
	input logic [7:0]          ioctl_index,
	input logic                ioctl_wr,
	input dl_pkg::dl_field_t   ioctl_addr,
	input dl_pkg::dl_word_t    ioctl_dout,
	input logic                ioctl_wait,
	input dl_pkg::dl_palette_t palette,
	input dl_pkg::dl_code_t    gg_code,
	input logic                gg_code_valid,
	input dl_pkg::dl_sum_t     checksum,
	input logic                using_real_cgb_boot,
	input logic                boot_gba_available,
	input logic                fastboot_available
);
	import dl_pkg::*;

	localparam int settle_limit = 200;

	int           errors = 0;
	int           checks = 0;
	int           wait_rises = 0;
	int           pulse_count = 0;
	int           exp_pulses = 0;
	dl_palette_t  exp_palette;
	logic [127:0] exp_code;
	dl_sum_t      exp_sum;
	logic         exp_custom_cgb, exp_custom_dmg;
	logic         prev_cgb, prev_dmg, wait_prev, cgb_now, dmg_now;
	dl_code_t     code_q[$];
	dl_code_t     want_code;

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// New word enters at the bottom, low byte above high byte
	function automatic dl_palette_t palette_shift(input dl_palette_t p, input dl_word_t w);
		return {p[111:0], w[7:0], w[15:8]};
	endfunction

	// Flags, address, compare, replace; low half at the lower field
	function automatic logic [127:0] code_put(input logic [127:0] c, input dl_field_t f,
		input dl_word_t w);
		logic [127:0] r;
		r = c;
		case (f)
			4'd0:  r[111:96]  = w;
			4'd2:  r[127:112] = w;
			4'd4:  r[79:64]   = w;
			4'd6:  r[95:80]   = w;
			4'd8:  r[47:32]   = w;
			4'd10: r[63:48]   = w;
			4'd12: r[15:0]    = w;
			4'd14: r[31:16]   = w;
			default: ;
		endcase
		return r;
	endfunction

	function automatic dl_sum_t sum_add(input dl_sum_t s, input dl_word_t w);
		return s + dl_sum_t'(w[15:8]) + dl_sum_t'(w[7:0]);
	endfunction

	// Returns {using_real_cgb_boot, boot_gba_available, fastboot_available}
	function automatic logic [2:0] expect_flags(input dl_sum_t s, input logic cc,
		input logic cd, input logic gbc);
		logic orig_hit, mister_hit, fast;
		orig_hit   = (s == `DL_CGB_ORIGINAL_SUM);
		mister_hit = (s == `DL_CGB_MISTER_SUM);
		fast       = gbc ? !(cc && !mister_hit) : !cd;
		return {orig_hit, !cc || orig_hit || mister_hit, fast};
	endfunction

	// Sampled at the falling edge, inputs and ioctl_wait are stable there
	always @(negedge clk_sys) begin
		if (reset) begin
			exp_palette    = `DL_PALETTE_RESET;
			exp_code       = '0;
			exp_sum        = '0;
			exp_custom_cgb = 1'b0;
			exp_custom_dmg = 1'b0;
			prev_cgb       = 1'b0;
			prev_dmg       = 1'b0;
			wait_prev      = 1'b0;
		end else begin
			if (gg_code_valid === 1'b1) begin
				pulse_count++;
				if (code_q.size() == 0) begin
					$display("gg_code_valid pulsed with no complete cheat code at %0t ns", $time);
					errors++;
				end else begin
					want_code = code_q.pop_front();
					checks++;
					if (gg_code !== want_code) begin
						$display("Error at %0t ns: gg_code expected %h, got %h",
							$time, want_code, gg_code);
						errors++;
					end
				end
			end
			if (ioctl_wait && !wait_prev)
				wait_rises++;
			wait_prev = ioctl_wait;
			// Bootrom downloads start on the first cycle of the strobe
			cgb_now = ioctl_download && (ioctl_index == `DL_FT_CGB_BOOT);
			dmg_now = ioctl_download && (ioctl_index == `DL_FT_DMG_BOOT);
			if (cgb_now && !prev_cgb) begin
				exp_sum        = '0;
				exp_custom_cgb = 1'b1;
			end
			if (dmg_now && !prev_dmg)
				exp_custom_dmg = 1'b1;
			prev_cgb = cgb_now;
			prev_dmg = dmg_now;
			if (ioctl_download && ioctl_wr && !ioctl_wait) begin
				case (ioctl_index)
					`DL_FT_PALETTE:
						exp_palette = palette_shift(exp_palette, ioctl_dout);
					`DL_FT_CHEAT: begin
						exp_code = code_put(exp_code, ioctl_addr, ioctl_dout);
						if (ioctl_addr == 4'd14) begin
							code_q.push_back({1'b1, exp_code});
							exp_pulses++;
						end
					end
					`DL_FT_CGB_BOOT:
						exp_sum = sum_add(exp_sum, ioctl_dout);
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare

	function automatic logic outputs_match();
		logic [2:0] f;
		f = expect_flags(exp_sum, exp_custom_cgb, exp_custom_dmg, is_gbc);
		return (palette === exp_palette) && (checksum === exp_sum) &&
		       (using_real_cgb_boot === f[2]) && (boot_gba_available === f[1]) &&
		       (fastboot_available === f[0]) && (pulse_count == exp_pulses);
	endfunction

	task automatic value_error(input string name, input logic [127:0] want,
		input logic [127:0] got);
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, want, got);
		errors++;
	endtask

	task automatic report_mismatches();
		logic [2:0] f;
		f = expect_flags(exp_sum, exp_custom_cgb, exp_custom_dmg, is_gbc);
		if (palette !== exp_palette)
			value_error("palette", exp_palette, palette);
		if (checksum !== exp_sum)
			value_error("checksum", exp_sum, checksum);
		if (using_real_cgb_boot !== f[2])
			value_error("using_real_cgb_boot", f[2], using_real_cgb_boot);
		if (boot_gba_available !== f[1])
			value_error("boot_gba_available", f[1], boot_gba_available);
		if (fastboot_available !== f[0])
			value_error("fastboot_available", f[0], fastboot_available);
		if (pulse_count != exp_pulses)
			value_error("gg_code_valid pulses", exp_pulses, pulse_count);
	endtask

	// Latency depends on FIFO occupancy, so wait for the outputs to settle
	task automatic compare_all(input string label);
		int n;
		n = 0;
		@(posedge clk_sys);
		#1;
		while (!outputs_match() && n < settle_limit) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		checks++;
		if (!outputs_match()) begin
			$display("Outputs did not reach the expected values within %0d cycles after %s",
				settle_limit, label);
			report_mismatches();
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] want,
		input logic [31:0] got);
		checks++;
		if (got !== want)
			value_error(name, want, got);
	endtask

endmodule

// ==== test/tb_dl_top.sv ====
// Testbench for the download stream top level.
// Runs palette, cheat and bootrom downloads with LFSR data through the DUT,
// including a burst that runs into back-pressure. All comparing is done
// by the dl_checker instance; this module prints the closing result.

`timescale 1ns/10ps
`include "dl_defs.svh"

module tb_dl_top;
	import dl_pkg::*;

	localparam int wait_limit = 64;

	logic        clk_sys = 1'b0;
	logic        reset, is_gbc, ioctl_download, ioctl_wr, ioctl_wait;
	logic [7:0]  ioctl_index;
	dl_field_t   ioctl_addr;
	dl_word_t    ioctl_dout;
	dl_palette_t palette;
	dl_code_t    gg_code;
	logic        gg_code_valid, using_real_cgb_boot, boot_gba_available, fastboot_available;
	dl_sum_t     checksum;
	logic [31:0] lfsr;
	int          fails = 0;
	int          byte_total, rises;

	always #20 clk_sys = ~clk_sys;

	dl_top uut (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.is_gbc              (is_gbc),
		.ioctl_download      (ioctl_download),
		.ioctl_index         (ioctl_index),
		.ioctl_wr            (ioctl_wr),
		.ioctl_addr          (ioctl_addr),
		.ioctl_dout          (ioctl_dout),
		.ioctl_wait          (ioctl_wait),
		.palette             (palette),
		.gg_code             (gg_code),
		.gg_code_valid       (gg_code_valid),
		.checksum            (checksum),
		.using_real_cgb_boot (using_real_cgb_boot),
		.boot_gba_available  (boot_gba_available),
		.fastboot_available  (fastboot_available)
	);

	dl_checker chk (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.is_gbc              (is_gbc),
		.ioctl_download      (ioctl_download),
		.ioctl_index         (ioctl_index),
		.ioctl_wr            (ioctl_wr),
		.ioctl_addr          (ioctl_addr),
		.ioctl_dout          (ioctl_dout),
		.ioctl_wait          (ioctl_wait),
		.palette             (palette),
		.gg_code             (gg_code),
		.gg_code_valid       (gg_code_valid),
		.checksum            (checksum),
		.using_real_cgb_boot (using_real_cgb_boot),
		.boot_gba_available  (boot_gba_available),
		.fastboot_available  (fastboot_available)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers, all return 2 ns after a rising edge

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_word(output dl_word_t w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[14:0], lfsr[0]};
		end
	endtask

	// ioctl_wait is registered, so its value now holds for the next edge
	task automatic write_word(input dl_field_t addr, input dl_word_t data);
		int n;
		n = 0;
		while (ioctl_wait !== 1'b0 && n < wait_limit) begin
			ioctl_wr = 1'b0;
			@(posedge clk_sys);
			#2;
			n++;
		end
		if (ioctl_wait !== 1'b0) begin
			$display("Timeout at %0t ns: ioctl_wait stayed high for %0d cycles, word dropped",
				$time, wait_limit);
			fails++;
		end else begin
			ioctl_wr   = 1'b1;
			ioctl_addr = addr;
			ioctl_dout = data;
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
	endtask

	task automatic end_download();
		ioctl_wr = 1'b0;
		@(posedge clk_sys);
		#2;
		ioctl_download = 1'b0;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic send_random(input int n, inout int total);
		dl_word_t w;
		for (int k = 0; k < n; k++) begin
			take_word(w);
			write_word(dl_field_t'(2 * k), w);
			total = total + w[15:8] + w[7:0];
		end
	endtask

	// Random words, then one last word that lands the byte sum on target
	task automatic send_cgb_to_sum(input int target);
		dl_word_t w;
		int total, left, k;
		total = 0;
		k = 0;
		while (target - total > 510) begin
			take_word(w);
			write_word(dl_field_t'(2 * k), w);
			total = total + w[15:8] + w[7:0];
			k++;
		end
		left = target - total;
		if (left > 255)
			w = {8'hFF, 8'(left - 255)};
		else
			w = {8'(left), 8'h00};
		write_word(dl_field_t'(2 * k), w);
	endtask

	task automatic settle(input string label);
		chk.compare_all(label);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		reset          = 1'b1;
		is_gbc         = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		byte_total     = 0;
		lfsr           = 32'h8ddb_066e;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		settle("reset");
		chk.check_value("ioctl_wait", 0, ioctl_wait);

		start_download(`DL_FT_PALETTE);
		send_random(8, byte_total);
		end_download();
		settle("palette download");

		// Two complete codes
		start_download(`DL_FT_CHEAT);
		send_random(16, byte_total);
		end_download();
		settle("cheat download");
		chk.check_value("gg_code_valid pulses", 2, chk.pulse_count);

		start_download(`DL_FT_CGB_BOOT);
		send_cgb_to_sum(`DL_CGB_ORIGINAL_SUM);
		end_download();
		settle("colour bootrom download");
		chk.check_value("checksum", `DL_CGB_ORIGINAL_SUM, checksum);
		chk.check_value("using_real_cgb_boot", 1, using_real_cgb_boot);
		chk.check_value("boot_gba_available", 1, boot_gba_available);
		chk.check_value("fastboot_available", 0, fastboot_available);
		is_gbc = 1'b0;
		settle("is_gbc low");
		chk.check_value("fastboot_available", 1, fastboot_available);
		is_gbc = 1'b1;

		start_download(`DL_FT_CGB_BOOT);
		send_random(40, byte_total);
		end_download();
		settle("random colour bootrom");

		// Burst at full write rate against the half rate checksum adder
		byte_total = 0;
		start_download(`DL_FT_CGB_BOOT);
		send_random(4, byte_total);
		rises = chk.wait_rises;
		send_random(20, byte_total);
		end_download();
		settle("colour bootrom burst");
		if (chk.wait_rises <= rises) begin
			$display("ioctl_wait never rose during the colour bootrom burst");
			fails++;
		end
		chk.check_value("checksum", byte_total, checksum);

		// Unused index, then writes with the download strobe low
		start_download(8'd7);
		send_random(6, byte_total);
		end_download();
		ioctl_index = `DL_FT_PALETTE;
		send_random(6, byte_total);
		ioctl_wr = 1'b0;
		settle("ignored words");

		is_gbc = 1'b0;
		start_download(`DL_FT_DMG_BOOT);
		send_random(4, byte_total);
		end_download();
		settle("mono bootrom download");
		chk.check_value("fastboot_available", 0, fastboot_available);

		$display("Checks: %0d, errors: %0d, other failures: %0d",
			chk.checks, chk.errors, fails);
		if (chk.errors == 0 && fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
design/dl_pkg.sv
design/dl_classify.sv
design/dl_credit_fifo.sv
design/dl_sink.sv
design/dl_top.sv
test/dl_checker.sv
test/tb_dl_top.sv
